// File: include/noc_defines.svh
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// router ports: north, south, west, east, local
`define NOC_NUM_PORTS 5

// next-hop and crossbar select code width
`define NOC_CODE_W 3

// inputs competing for one output, own port excluded
`define NOC_NUM_CAND 4

// downstream buffer slots per output
`define NOC_BUF_DEPTH 4

// wide enough to hold NOC_BUF_DEPTH
`define NOC_CREDIT_W 3

`endif

// File: verilog/noc_pkg.sv
`include "noc_defines.svh"

package noc_pkg;

        // port codes, shared by next-hop requests and crossbar selects
        // codes 5 and 6 are never matched and behave as idle
        typedef enum logic [`NOC_CODE_W-1:0] {
                PORT_NORTH = 3'd0,
                PORT_SOUTH = 3'd1,
                PORT_WEST  = 3'd2,
                PORT_EAST  = 3'd3,
                PORT_LOCAL = 3'd4,
                PORT_IDLE  = 3'd7
        } port_code_t;

endpackage

// File: verilog/sw_alloc_if.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

interface sw_alloc_if;

        // one entry per input port
        noc_pkg::port_code_t req_code [`NOC_NUM_PORTS];

        // everything below is indexed by output port
        logic [`NOC_NUM_PORTS-1:0]                     credit_ok;
        logic [`NOC_NUM_PORTS-1:0][`NOC_NUM_PORTS-1:0] grant;
        noc_pkg::port_code_t                           xbar_sel [`NOC_NUM_PORTS];
        logic [`NOC_NUM_PORTS-1:0]                     granted;

        modport top (output req_code, input grant, input xbar_sel);

        modport arb (
                input  req_code,
                input  credit_ok,
                output grant,
                output xbar_sel,
                output granted
        );

        modport credit (input granted, output credit_ok);

endinterface

// File: verilog/rr_order_ring.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module rr_order_ring (
        input  logic                                        clk,
        input  logic                                        reset_i,
        input  logic                                        rotate_i,
        output logic [`NOC_NUM_CAND-1:0][`NOC_NUM_CAND-1:0] rank_o
);

        localparam int NUM_CAND = `NOC_NUM_CAND;

        logic [NUM_CAND-1:0][NUM_CAND-1:0] rank_q;
        logic [NUM_CAND-1:0]               rank_union;

        // word 0 is the top rank
        always_ff @(posedge clk) begin
                if (reset_i) begin
                        for (int r = 0; r < NUM_CAND; r++) begin
                                rank_q[r] <= NUM_CAND'(1) << r;
                        end
                end else if (rotate_i) begin
                        // everyone moves up one and the old top drops to the bottom
                        for (int r = 0; r < NUM_CAND - 1; r++) begin
                                rank_q[r] <= rank_q[r+1];
                        end
                        rank_q[NUM_CAND-1] <= rank_q[0];
                end
        end

        assign rank_o = rank_q;

        always_comb begin
                rank_union = '0;
                for (int r = 0; r < NUM_CAND; r++) begin
                        rank_union = rank_union | rank_q[r];
                end
        end

        for (genvar r = 0; r < NUM_CAND; r++) begin : g_onehot_chk
                a_rank_onehot: assert property (@(posedge clk) disable iff (reset_i)
                        $onehot(rank_q[r]));
        end

        // one-hot words covering every candidate means a permutation
        a_rank_perm: assert property (@(posedge clk) disable iff (reset_i)
                rank_union == {NUM_CAND{1'b1}});

endmodule

// File: verilog/rr_output_arbiter.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module rr_output_arbiter #(
        parameter int OUT_PORT = 0
) (
        input  logic    clk,
        input  logic    reset_i,
        sw_alloc_if.arb bus
);

        localparam int NUM_CAND = `NOC_NUM_CAND;
        localparam int RANK_W   = $clog2(NUM_CAND);

        logic [NUM_CAND-1:0]               desire;
        logic [NUM_CAND-1:0][NUM_CAND-1:0] rank;
        logic [NUM_CAND-1:0]               rank_hit;
        logic [RANK_W-1:0]                 top_rank;
        logic                              any_hit;
        logic [NUM_CAND-1:0]               win_cand;
        logic                              grant_en;
        logic [`NOC_NUM_PORTS-1:0]         grant_word;
        noc_pkg::port_code_t               sel_code;

        // candidate slot c maps to an input port other than our own
        function automatic int cand_port(input int c);
                return (c < OUT_PORT) ? c : c + 1;
        endfunction

        rr_order_ring u_ring (
                .clk      (clk),
                .reset_i  (reset_i),
                .rotate_i (grant_en),
                .rank_o   (rank)
        );

        // which candidates want this output
        always_comb begin
                for (int c = 0; c < NUM_CAND; c++) begin
                        desire[c] = (bus.req_code[cand_port(c)] ==
                                     noc_pkg::port_code_t'(OUT_PORT));
                end
        end

        always_comb begin
                for (int r = 0; r < NUM_CAND; r++) begin
                        rank_hit[r] = |(rank[r] & desire);
                end
        end

        // scan from the bottom so the best rank is written last
        always_comb begin
                top_rank = '0;
                any_hit  = 1'b0;
                for (int r = NUM_CAND - 1; r >= 0; r--) begin
                        if (rank_hit[r]) begin
                                top_rank = RANK_W'(r);
                                any_hit  = 1'b1;
                        end
                end
        end

        assign win_cand = rank[top_rank];
        assign grant_en = any_hit & bus.credit_ok[OUT_PORT];

        always_comb begin
                grant_word = '0;
                sel_code   = noc_pkg::PORT_IDLE;
                for (int c = 0; c < NUM_CAND; c++) begin
                        if (grant_en && win_cand[c]) begin
                                grant_word[cand_port(c)] = 1'b1;
                                sel_code = noc_pkg::port_code_t'(cand_port(c));
                        end
                end
        end

        assign bus.grant[OUT_PORT]    = grant_word;
        assign bus.xbar_sel[OUT_PORT] = sel_code;
        assign bus.granted[OUT_PORT]  = grant_en;

        // no u-turns and at most one winner
        a_grant_legal: assert property (@(posedge clk) disable iff (reset_i)
                $onehot0(grant_word) && !grant_word[OUT_PORT]);

endmodule

// File: verilog/credit_tracker.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module credit_tracker #(
        parameter int DEPTH   = `NOC_BUF_DEPTH,
        parameter int OUT_IDX = 0
) (
        input  logic       clk,
        input  logic       reset_i,
        input  logic       credit_return_i,
        sw_alloc_if.credit bus
);

        logic [`NOC_CREDIT_W-1:0] count_q;
        logic                     take;

        assign take = bus.granted[OUT_IDX];

        // grant and return together cancel out
        always_ff @(posedge clk) begin
                if (reset_i) begin
                        count_q <= `NOC_CREDIT_W'(DEPTH);
                end else if (take && !credit_return_i) begin
                        count_q <= count_q - 1'b1;
                end else if (credit_return_i && !take) begin
                        count_q <= count_q + 1'b1;
                end
        end

        assign bus.credit_ok[OUT_IDX] = (count_q != '0);

        // arbiter must not grant into an empty buffer
        a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
                (take && !credit_return_i) |-> count_q != '0);

        // downstream cannot return more slots than it has
        a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
                (credit_return_i && !take) |-> count_q < DEPTH);

endmodule

// File: verilog/switch_allocator.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module switch_allocator (
        input  logic                                     clk,
        input  logic                                     reset_i,
        input  logic [`NOC_NUM_PORTS*`NOC_CODE_W-1:0]    nexthop_i,
        input  logic [`NOC_NUM_PORTS-1:0]                credit_return_i,
        output logic [`NOC_NUM_PORTS*`NOC_NUM_PORTS-1:0] grant_o,
        output logic [`NOC_NUM_PORTS*`NOC_CODE_W-1:0]    xbar_sel_o
);

        sw_alloc_if bus ();

        for (genvar p = 0; p < `NOC_NUM_PORTS; p++) begin : g_port
                // flat input ports onto the bus
                assign bus.req_code[p] =
                        noc_pkg::port_code_t'(nexthop_i[p*`NOC_CODE_W +: `NOC_CODE_W]);

                // word p of each output belongs to output port p
                assign grant_o[p*`NOC_NUM_PORTS +: `NOC_NUM_PORTS]  = bus.grant[p];
                assign xbar_sel_o[p*`NOC_CODE_W +: `NOC_CODE_W]     = bus.xbar_sel[p];

                rr_output_arbiter #(
                        .OUT_PORT (p)
                ) u_arb (
                        .clk     (clk),
                        .reset_i (reset_i),
                        .bus     (bus.arb)
                );

                credit_tracker #(
                        .DEPTH   (`NOC_BUF_DEPTH),
                        .OUT_IDX (p)
                ) u_credit (
                        .clk             (clk),
                        .reset_i         (reset_i),
                        .credit_return_i (credit_return_i[p]),
                        .bus             (bus.credit)
                );
        end

endmodule

// File: dv/tb_switch_allocator.sv
`timescale 1ns/10ps
`include "noc_defines.svh"

module tb_switch_allocator;

        localparam int NP         = `NOC_NUM_PORTS;
        localparam int CW         = `NOC_CODE_W;
        localparam int NC         = `NOC_NUM_CAND;
        localparam int DEPTH      = `NOC_BUF_DEPTH;
        localparam int CLK_PERIOD = 40;
        localparam int BP_OUT     = 3;
        localparam int RAND_CYCLES = 400;

        localparam int RESET_CYCLES = 12;
        localparam int T1_CYCLES    = 1 + (DEPTH + 2) + DEPTH;
        localparam int T2_CYCLES    = NP * 8;
        localparam int T3_CYCLES    = RESET_CYCLES + 16;
        localparam int T4_CYCLES    = RESET_CYCLES + (DEPTH + 2) + 5;
        localparam int WATCHDOG_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES +
                                         T4_CYCLES + RAND_CYCLES + 50;

        localparam logic [NP*CW-1:0] IDLE_ALL = {NP{CW'(noc_pkg::PORT_IDLE)}};

        logic                clk;
        logic                reset_i;
        logic [NP*CW-1:0]    nexthop_i;
        logic [NP-1:0]       credit_return_i;
        logic [NP*NP-1:0]    grant_o;
        logic [NP*CW-1:0]    xbar_sel_o;

        // reference model state
        int                  m_rank [NP][NC];
        int                  m_count [NP];
        logic [NP*NP-1:0]    exp_grant;
        logic [NP*CW-1:0]    exp_sel;
        logic [NP-1:0]       exp_granted;

        logic [31:0]         lfsr_state = 32'h52ace2b8;
        int                  n_checks;
        int                  n_errors;
        int                  err_at_start;
        int                  grants_seen [NP];

        switch_allocator u_switch_allocator (
                .clk             (clk),
                .reset_i         (reset_i),
                .nexthop_i       (nexthop_i),
                .credit_return_i (credit_return_i),
                .grant_o         (grant_o),
                .xbar_sel_o      (xbar_sel_o)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        // taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                logic fb;
                fb = s[31] ^ s[21] ^ s[1] ^ s[0];
                return {s[30:0], fb};
        endfunction

        task automatic draw_bits(input int n, output logic [31:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        v[i] = lfsr_state[0];
                end
        endtask

        // inputs other than o in increasing code order
        function automatic int cand_port(input int o, input int c);
                return (c < o) ? c : c + 1;
        endfunction

        function automatic logic [NP*CW-1:0] set_code(input logic [NP*CW-1:0] nh,
                                                      input int p, input int code);
                nh[p*CW +: CW] = CW'(code);
                return nh;
        endfunction

        task automatic model_reset();
                for (int o = 0; o < NP; o++) begin
                        m_count[o] = DEPTH;
                        for (int r = 0; r < NC; r++) begin
                                m_rank[o][r] = r;
                        end
                end
        endtask

        task automatic predict(input logic [NP*CW-1:0] nh);
                int c;
                int p;
                exp_grant   = '0;
                exp_sel     = IDLE_ALL;
                exp_granted = '0;
                for (int o = 0; o < NP; o++) begin
                        for (int r = 0; r < NC; r++) begin
                                c = m_rank[o][r];
                                p = cand_port(o, c);
                                if (!exp_granted[o] && m_count[o] > 0 &&
                                    int'(nh[p*CW +: CW]) == o) begin
                                        exp_granted[o]        = 1'b1;
                                        exp_grant[o*NP + p]   = 1'b1;
                                        exp_sel[o*CW +: CW]   = CW'(p);
                                end
                        end
                end
        endtask

        task automatic model_update(input logic [NP-1:0] ret);
                int top;
                for (int o = 0; o < NP; o++) begin
                        if (exp_granted[o]) begin
                                top = m_rank[o][0];
                                for (int r = 0; r < NC - 1; r++) begin
                                        m_rank[o][r] = m_rank[o][r+1];
                                end
                                m_rank[o][NC-1] = top;
                        end
                        if (exp_granted[o] && !ret[o]) begin
                                m_count[o]--;
                        end else if (ret[o] && !exp_granted[o]) begin
                                m_count[o]++;
                        end
                end
        endtask

        task automatic apply_reset();
                @(negedge clk);
                reset_i         = 1'b1;
                nexthop_i       = IDLE_ALL;
                credit_return_i = '0;
                repeat (10) @(negedge clk);
                reset_i = 1'b0;
                model_reset();
        endtask

        // returns are dropped where the downstream buffer is already full
        task automatic run_cycle(input logic [NP*CW-1:0] nh, input logic [NP-1:0] ret_req);
                logic [NP-1:0] ret;
                @(negedge clk);
                predict(nh);
                for (int o = 0; o < NP; o++) begin
                        ret[o] = ret_req[o] && (m_count[o] < DEPTH || exp_granted[o]);
                end
                nexthop_i       = nh;
                credit_return_i = ret;
                #5;
                n_checks++;
                if (grant_o !== exp_grant) begin
                        $display("FAIL grant_o expected 0x%h got 0x%h", exp_grant, grant_o);
                        n_errors++;
                end
                if (xbar_sel_o !== exp_sel) begin
                        $display("FAIL xbar_sel_o expected 0x%h got 0x%h", exp_sel, xbar_sel_o);
                        n_errors++;
                end
                for (int o = 0; o < NP; o++) begin
                        if (|grant_o[o*NP +: NP]) begin
                                grants_seen[o]++;
                        end
                end
                model_update(ret);
        endtask

        task automatic clear_grant_counts();
                for (int o = 0; o < NP; o++) begin
                        grants_seen[o] = 0;
                end
        endtask

        task automatic expect_grant_count(input int o, input int n);
                n_checks++;
                if (grants_seen[o] != n) begin
                        $display("FAIL grant_o[%0d] grant count expected 0x%h got 0x%h",
                                 o, n, grants_seen[o]);
                        n_errors++;
                end
        endtask

        task automatic end_test(input string name);
                $display("test %s done, %0d errors", name, n_errors - err_at_start);
                err_at_start = n_errors;
        endtask

        initial begin
                logic [NP*CW-1:0] nh;
                logic [31:0]      bits;
                logic [31:0]      ret_bits;
                int               exp_port;

                clk             = 1'b0;
                reset_i         = 1'b1;
                nexthop_i       = IDLE_ALL;
                credit_return_i = '0;
                n_checks        = 0;
                n_errors        = 0;
                err_at_start    = 0;
                apply_reset();

                // each output has one requester and no returns
                run_cycle(IDLE_ALL, '0);
                nh = IDLE_ALL;
                for (int p = 0; p < NP; p++) begin
                        nh = set_code(nh, p, (p + 1) % NP);
                end
                clear_grant_counts();
                repeat (DEPTH + 2) run_cycle(nh, '0);
                for (int o = 0; o < NP; o++) begin
                        expect_grant_count(o, DEPTH);
                end
                repeat (DEPTH) run_cycle(IDLE_ALL, '1);
                end_test("1 reset state");

                for (int p = 0; p < NP; p++) begin
                        for (int k = 0; k < 8; k++) begin
                                run_cycle(set_code(IDLE_ALL, p, k), '1);
                                if (k == p || k >= NP) begin
                                        if (grant_o !== '0) begin
                                                $display("FAIL grant_o expected 0x%h got 0x%h",
                                                         {NP*NP{1'b0}}, grant_o);
                                                n_errors++;
                                        end
                                end else if (xbar_sel_o[k*CW +: CW] !== CW'(p)) begin
                                        $display("FAIL xbar_sel_o[%0d] expected 0x%h got 0x%h",
                                                 k, CW'(p), xbar_sel_o[k*CW +: CW]);
                                        n_errors++;
                                end
                        end
                end
                end_test("2 lone requester");

                // four inputs fight for west and the winners walk the candidate list
                apply_reset();
                nh = IDLE_ALL;
                for (int p = 0; p < NP; p++) begin
                        if (p != 2) begin
                                nh = set_code(nh, p, 2);
                        end
                end
                for (int n = 0; n < 16; n++) begin
                        run_cycle(nh, '1);
                        exp_port = cand_port(2, n % NC);
                        if (xbar_sel_o[2*CW +: CW] !== CW'(exp_port)) begin
                                $display("FAIL xbar_sel_o[2] expected 0x%h got 0x%h",
                                         CW'(exp_port), xbar_sel_o[2*CW +: CW]);
                                n_errors++;
                        end
                end
                end_test("3 round robin");

                // every candidate wants east so a stray rotation changes the winner
                apply_reset();
                nh = IDLE_ALL;
                for (int p = 0; p < NP; p++) begin
                        if (p != BP_OUT) begin
                                nh = set_code(nh, p, BP_OUT);
                        end
                end
                clear_grant_counts();
                repeat (DEPTH + 2) run_cycle(nh, '0);
                expect_grant_count(BP_OUT, DEPTH);
                clear_grant_counts();
                // a lone pulse and then a pulse alongside a grant
                run_cycle(nh, NP'(1) << BP_OUT);
                run_cycle(nh, NP'(1) << BP_OUT);
                run_cycle(nh, '0);
                run_cycle(nh, '0);
                run_cycle(nh, '0);
                expect_grant_count(BP_OUT, 2);
                end_test("4 credit back-pressure");

                for (int n = 0; n < RAND_CYCLES; n++) begin
                        draw_bits(NP * CW, bits);
                        draw_bits(NP, ret_bits);
                        run_cycle(bits[NP*CW-1:0], ret_bits[NP-1:0]);
                end
                end_test("5 random traffic");

                $display("checks %0d, errors %0d", n_checks, n_errors);
                if (n_errors == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_CYCLES * CLK_PERIOD);
                $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
                $display("CHECKS FAILED");
                $finish;
        end

endmodule

// File: src.f
+incdir+include
verilog/noc_pkg.sv
verilog/sw_alloc_if.sv
verilog/rr_order_ring.sv
verilog/rr_output_arbiter.sv
verilog/credit_tracker.sv
verilog/switch_allocator.sv
dv/tb_switch_allocator.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_switch_allocator
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
